//--- src/axi_macros.svh
`ifndef AXI_MACROS_SVH
`define AXI_MACROS_SVH

// Channel field widths
`define AXI_ID_BITS   4
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_LEN_BITS  8
`define AXI_SIZE_BITS 3

// INCR burst encoding
`define AXI_BURST_INC 2'b01

// Memory depth in words, power of two
`define AXI_MEM_WORDS 256

// Idle cycles before BVALID or RVALID
`define AXI_SLAVE_WAIT 1

`endif

//--- src/axi_pkg.sv
`include "axi_macros.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axi_resp_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
    logic [`AXI_SIZE_BITS-1:0] size;
    logic [1:0]                burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
    logic [`AXI_SIZE_BITS-1:0] size;
    logic [1:0]                burst;
  } axi_ar_t;

  typedef struct packed {
    logic [`AXI_DATA_BITS-1:0] data;
    logic [`AXI_STRB_BITS-1:0] strb;
    logic                      last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0] id;
    axi_resp_t               resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_DATA_BITS-1:0] data;
    axi_resp_t                 resp;
    logic                      last;
  } axi_r_t;

  typedef enum logic [2:0] {IDLE, AR, R, AW, W, B} master_state_t;

endpackage

//--- src/axi_master.sv
`timescale 1ns/1ps
`include "axi_macros.svh"

module axi_master (
  input  logic                      clk,
  input  logic                      rstn,
  // CPU side
  input  logic                      read,
  input  logic                      write,
  input  logic [`AXI_ADDR_BITS-1:0] addr,
  input  logic [`AXI_DATA_BITS-1:0] data_in,
  input  logic [`AXI_STRB_BITS-1:0] w_type,
  output logic [`AXI_DATA_BITS-1:0] data_out,
  output logic                      stall,
  // Write address
  output axi_pkg::axi_aw_t          aw,
  output logic                      aw_valid,
  input  logic                      aw_ready,
  // Write data
  output axi_pkg::axi_w_t           w,
  output logic                      w_valid,
  input  logic                      w_ready,
  // Write response
  input  axi_pkg::axi_b_t           b,
  input  logic                      b_valid,
  output logic                      b_ready,
  // Read address
  output axi_pkg::axi_ar_t          ar,
  output logic                      ar_valid,
  input  logic                      ar_ready,
  // Read data
  input  axi_pkg::axi_r_t           r,
  input  logic                      r_valid,
  output logic                      r_ready
);
  import axi_pkg::*;

  // Every beat moves one whole data word
  localparam logic [`AXI_SIZE_BITS-1:0] FULL_SIZE = `AXI_SIZE_BITS'($clog2(`AXI_STRB_BITS));

  master_state_t state;
  master_state_t next_state;
  master_state_t req_state;

  logic [`AXI_ADDR_BITS-1:0] addr_q;
  logic [`AXI_DATA_BITS-1:0] wdata_q;
  logic [`AXI_STRB_BITS-1:0] wstrb_q;
  logic [`AXI_DATA_BITS-1:0] rdata_q;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;
  logic start_aw;
  logic start_ar;

  assign aw_hs = aw_valid & aw_ready;
  assign w_hs  = w_valid & w_ready;
  assign b_hs  = b_valid & b_ready;
  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;

  // Where a new CPU request would take us, write first
  always_comb begin
    if (write)
      req_state = AW;
    else if (read)
      req_state = AR;
    else
      req_state = IDLE;
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: next_state = req_state;
      AR:   next_state = ar_hs ? R : AR;
      R:    next_state = r_hs ? req_state : R;
      AW: begin
        if (aw_hs)
          next_state = w_hs ? B : W;
      end
      W: begin
        if (w_hs)
          next_state = b_hs ? req_state : B;
      end
      B:    next_state = b_hs ? req_state : B;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Request is captured on the edge that enters AW or AR
  assign start_aw = (next_state == AW) && (state != AW);
  assign start_ar = (next_state == AR) && (state != AR);

  always_ff @(posedge clk) begin
    if (start_aw || start_ar)
      addr_q <= addr;
    if (start_aw) begin
      wdata_q <= data_in;
      wstrb_q <= w_type;
    end
  end

  // Last read word, kept for the CPU
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_q <= '0;
    end else if (r_hs) begin
      rdata_q <= r.data;
    end
  end

  assign data_out = r_hs ? r.data : rdata_q;

  // Single beat INCR, ID zero
  assign aw = '{
    id:    '0,
    addr:  addr_q,
    len:   '0,
    size:  FULL_SIZE,
    burst: `AXI_BURST_INC
  };

  assign ar = '{
    id:    '0,
    addr:  addr_q,
    len:   '0,
    size:  FULL_SIZE,
    burst: `AXI_BURST_INC
  };

  assign w = '{
    data: wdata_q,
    strb: wstrb_q,
    last: 1'b1
  };

  always_comb begin
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    stall    = 1'b0;
    case (state)
      AR: begin
        ar_valid = 1'b1;
        stall    = 1'b1;
      end
      R: r_ready = 1'b1;
      AW: begin
        aw_valid = 1'b1;
        // Data goes out with the accepted address
        w_valid  = aw_hs;
        stall    = 1'b1;
      end
      W: begin
        w_valid = 1'b1;
        b_ready = 1'b1;
        stall   = 1'b1;
      end
      B: b_ready = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- src/axi_sram_slave.sv
`timescale 1ns/1ps
`include "axi_macros.svh"

module axi_sram_slave (
  input  logic             clk,
  input  logic             rstn,
  // Write address
  input  axi_pkg::axi_aw_t aw,
  input  logic             aw_valid,
  output logic             aw_ready,
  // Write data
  input  axi_pkg::axi_w_t  w,
  input  logic             w_valid,
  output logic             w_ready,
  // Write response
  output axi_pkg::axi_b_t  b,
  output logic             b_valid,
  input  logic             b_ready,
  // Read address
  input  axi_pkg::axi_ar_t ar,
  input  logic             ar_valid,
  output logic             ar_ready,
  // Read data
  output axi_pkg::axi_r_t  r,
  output logic             r_valid,
  input  logic             r_ready
);
  import axi_pkg::*;

  localparam int OFFSET_BITS = $clog2(`AXI_STRB_BITS);
  localparam int INDEX_BITS  = $clog2(`AXI_MEM_WORDS);
  localparam int CNT_BITS    = $clog2(`AXI_SLAVE_WAIT + 2);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_WDATA = 2'd1;
  localparam logic [1:0] S_DELAY = 2'd2;
  localparam logic [1:0] S_RESP  = 2'd3;

  logic [`AXI_DATA_BITS-1:0] mem [`AXI_MEM_WORDS];

  logic [1:0]                state;
  logic [CNT_BITS-1:0]       wait_cnt;
  logic                      rd_pending;
  logic [`AXI_ADDR_BITS-1:0] awaddr_q;
  logic [`AXI_ADDR_BITS-1:0] wr_addr;
  logic [INDEX_BITS-1:0]     wr_idx;
  logic [INDEX_BITS-1:0]     rd_idx;
  logic                      wr_hit;
  logic                      rd_hit;
  logic [`AXI_DATA_BITS-1:0] merged;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic resp_hs;
  logic wr_en;
  logic accept;

  assign aw_hs   = aw_valid & aw_ready;
  assign w_hs    = w_valid & w_ready;
  assign ar_hs   = ar_valid & ar_ready;
  assign resp_hs = (b_valid & b_ready) | (r_valid & r_ready);

  // Idle takes any request, a pending AW blocks AR
  assign aw_ready = (state == S_IDLE);
  assign w_ready  = (state == S_IDLE) || (state == S_WDATA);
  assign ar_ready = (state == S_IDLE) && !aw_valid;

  assign b_valid = (state == S_RESP) && !rd_pending;
  assign r_valid = (state == S_RESP) && rd_pending;

  // W ahead of its AW is not supported and is ignored
  assign wr_en  = w_hs && (aw_hs || (state == S_WDATA));
  assign accept = wr_en || ar_hs;

  // Word decode, upper address bits must be clear
  assign wr_addr = (state == S_WDATA) ? awaddr_q : aw.addr;
  assign wr_idx  = wr_addr[OFFSET_BITS +: INDEX_BITS];
  assign rd_idx  = ar.addr[OFFSET_BITS +: INDEX_BITS];
  assign wr_hit  = (wr_addr[`AXI_ADDR_BITS-1:OFFSET_BITS+INDEX_BITS] == '0);
  assign rd_hit  = (ar.addr[`AXI_ADDR_BITS-1:OFFSET_BITS+INDEX_BITS] == '0);

  // Byte lane merge
  always_comb begin
    merged = mem[wr_idx];
    for (int i = 0; i < `AXI_STRB_BITS; i++) begin
      if (w.strb[i])
        merged[8*i +: 8] = w.data[8*i +: 8];
    end
  end

  // Cleared on reset so reads start at zero
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `AXI_MEM_WORDS; i++)
        mem[i] <= '0;
    end else if (wr_en && wr_hit) begin
      mem[wr_idx] <= merged;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= S_IDLE;
      wait_cnt   <= '0;
      rd_pending <= 1'b0;
    end else begin
      case (state)
        S_IDLE, S_WDATA: begin
          if (accept) begin
            rd_pending <= ar_hs;
            if (`AXI_SLAVE_WAIT == 0) begin
              state <= S_RESP;
            end else begin
              state    <= S_DELAY;
              wait_cnt <= CNT_BITS'(`AXI_SLAVE_WAIT - 1);
            end
          end else if (aw_hs) begin
            state <= S_WDATA;
          end
        end
        S_DELAY: begin
          if (wait_cnt == '0)
            state <= S_RESP;
          else
            wait_cnt <= wait_cnt - 1'b1;
        end
        S_RESP: begin
          if (resp_hs)
            state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Response payload, ID echoed from the request
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      awaddr_q <= aw.addr;
      b.id     <= aw.id;
    end
    if (wr_en)
      b.resp <= wr_hit ? OKAY : DECERR;
    if (ar_hs) begin
      r.id   <= ar.id;
      r.data <= rd_hit ? mem[rd_idx] : '0;
      r.resp <= rd_hit ? OKAY : DECERR;
      r.last <= 1'b1;
    end
  end

endmodule

//--- src/axi_mem_subsys.sv
`timescale 1ns/1ps
`include "axi_macros.svh"

module axi_mem_subsys (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      read,
  input  logic                      write,
  input  logic [`AXI_ADDR_BITS-1:0] addr,
  input  logic [`AXI_DATA_BITS-1:0] data_in,
  input  logic [`AXI_STRB_BITS-1:0] w_type,
  output logic [`AXI_DATA_BITS-1:0] data_out,
  output logic                      stall
);
  import axi_pkg::*;

  // One struct per channel plus its handshake pair
  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  axi_ar_t ar;
  axi_r_t  r;

  logic aw_valid;
  logic aw_ready;
  logic w_valid;
  logic w_ready;
  logic b_valid;
  logic b_ready;
  logic ar_valid;
  logic ar_ready;
  logic r_valid;
  logic r_ready;

  axi_master u_master (
    .clk      (clk),
    .rstn     (rstn),
    .read     (read),
    .write    (write),
    .addr     (addr),
    .data_in  (data_in),
    .w_type   (w_type),
    .data_out (data_out),
    .stall    (stall),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
  );

  axi_sram_slave u_slave (
    .clk      (clk),
    .rstn     (rstn),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
  );

endmodule

//--- tests/tb_axi_mem_subsys.sv
`timescale 1ns/1ps
`include "axi_macros.svh"

module tb_axi_mem_subsys;
  import axi_pkg::*;

  localparam int OFFSET_BITS = $clog2(`AXI_STRB_BITS);
  localparam int INDEX_BITS  = $clog2(`AXI_MEM_WORDS);
  // 12 + 4 x wait cycles of 8 ns for each of 200 operations
  localparam longint TIMEOUT_NS = 200 * (12 + 4 * `AXI_SLAVE_WAIT) * 8;

  logic                      clk;
  logic                      rstn;
  logic                      read;
  logic                      write;
  logic [`AXI_ADDR_BITS-1:0] addr;
  logic [`AXI_DATA_BITS-1:0] data_in;
  logic [`AXI_STRB_BITS-1:0] w_type;
  logic [`AXI_DATA_BITS-1:0] data_out;
  logic                      stall;

  // Expected memory contents
  logic [`AXI_DATA_BITS-1:0] ref_mem [`AXI_MEM_WORDS];

  int     errors;
  int     checks;
  integer seed;

  axi_mem_subsys DUT (
    .clk      (clk),
    .rstn     (rstn),
    .read     (read),
    .write    (write),
    .addr     (addr),
    .data_in  (data_in),
    .w_type   (w_type),
    .data_out (data_out),
    .stall    (stall)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic in_range(input logic [`AXI_ADDR_BITS-1:0] a);
    return (a >> OFFSET_BITS) < `AXI_MEM_WORDS;
  endfunction

  function automatic logic [`AXI_DATA_BITS-1:0] expected_word(input logic [`AXI_ADDR_BITS-1:0] a);
    if (in_range(a))
      return ref_mem[a[OFFSET_BITS +: INDEX_BITS]];
    return '0;
  endfunction

  task automatic model_write(input logic [`AXI_ADDR_BITS-1:0] a,
                             input logic [`AXI_DATA_BITS-1:0] d,
                             input logic [`AXI_STRB_BITS-1:0] m);
    logic [`AXI_DATA_BITS-1:0] word;
    if (!in_range(a))
      return;
    word = ref_mem[a[OFFSET_BITS +: INDEX_BITS]];
    for (int i = 0; i < `AXI_STRB_BITS; i++) begin
      if (m[i])
        word[8*i +: 8] = d[8*i +: 8];
    end
    ref_mem[a[OFFSET_BITS +: INDEX_BITS]] = word;
  endtask

  task automatic check_value(input string what,
                             input logic [`AXI_DATA_BITS-1:0] exp,
                             input logic [`AXI_DATA_BITS-1:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0d ns: %s expected %h, observed %h", $time, what, exp, got);
    end
  endtask

  // Hold the request until stall shows it was taken, then wait out the response
  task automatic finish_request();
    @(negedge clk);
    while (!stall)
      @(negedge clk);
    @(posedge clk);
    read  <= 1'b0;
    write <= 1'b0;
    @(negedge clk);
    while (stall)
      @(negedge clk);
    repeat (`AXI_SLAVE_WAIT + 1) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic write_word(input logic [`AXI_ADDR_BITS-1:0] a,
                            input logic [`AXI_DATA_BITS-1:0] d,
                            input logic [`AXI_STRB_BITS-1:0] m);
    @(posedge clk);
    write   <= 1'b1;
    addr    <= a;
    data_in <= d;
    w_type  <= m;
    finish_request();
    model_write(a, d, m);
  endtask

  task automatic read_and_check(input logic [`AXI_ADDR_BITS-1:0] a);
    @(posedge clk);
    read <= 1'b1;
    addr <= a;
    finish_request();
    check_value($sformatf("read of %h", a), expected_word(a), data_out);
  endtask

  task automatic reset_state_check();
    check_value("stall after reset", '0, `AXI_DATA_BITS'(stall));
    check_value("data_out after reset", '0, data_out);
    read_and_check(32'h0000_0000);
    read_and_check(32'h0000_0040);
    read_and_check(32'((`AXI_MEM_WORDS - 1) * 4));
  endtask

  task automatic write_read_basic();
    write_word(32'h0000_0010, 32'h1234_5678, 4'hF);
    write_word(32'h0000_0014, 32'hCAFE_F00D, 4'hF);
    write_word(32'h0000_0100, 32'hA5A5_5A5A, 4'hF);
    read_and_check(32'h0000_0010);
    read_and_check(32'h0000_0014);
    read_and_check(32'h0000_0100);
  endtask

  task automatic strobe_merge();
    write_word(32'h0000_0020, 32'h1122_3344, 4'hF);
    write_word(32'h0000_0020, 32'hFFFF_FFAA, 4'b0001);
    read_and_check(32'h0000_0020);
    write_word(32'h0000_0020, 32'h00BB_0000, 4'b0100);
    read_and_check(32'h0000_0020);
    write_word(32'h0000_0020, 32'hDDEE_7777, 4'b1100);
    read_and_check(32'h0000_0020);
  endtask

  task automatic out_of_range_write();
    write_word(32'h0000_0008, 32'h0BAD_0008, 4'hF);
    // Same low index bits as word 2
    write_word(32'(`AXI_MEM_WORDS * 4 + 8), 32'hDEAD_BEEF, 4'hF);
    read_and_check(32'h0000_0008);
    read_and_check(32'(`AXI_MEM_WORDS * 4 + 8));
    write_word(32'h8000_0008, 32'hFEED_FACE, 4'hF);
    read_and_check(32'h0000_0008);
  endtask

  task automatic data_out_hold();
    logic [`AXI_DATA_BITS-1:0] held;
    write_word(32'h0000_0030, 32'h7654_3210, 4'hF);
    read_and_check(32'h0000_0030);
    held = expected_word(32'h0000_0030);
    write_word(32'h0000_0034, 32'h0F0F_F0F0, 4'hF);
    check_value("data_out held after write", held, data_out);
    write_word(32'h0000_0030, 32'h89AB_CDEF, 4'hF);
    check_value("data_out held after rewrite", held, data_out);
    read_and_check(32'h0000_0034);
  endtask

  task automatic random_mix();
    logic [31:0]               r;
    logic                      do_write;
    logic [`AXI_ADDR_BITS-1:0] a;
    logic [`AXI_DATA_BITS-1:0] d;
    logic [`AXI_STRB_BITS-1:0] m;
    for (int n = 0; n < 100; n++) begin
      r = $random(seed);
      do_write = r[0];
      r = $random(seed);
      // One in eight lands outside the memory
      if (r[2:0] == 3'd0)
        a = $random(seed) | 32'(`AXI_MEM_WORDS * 4);
      else
        a = 32'(r[7:4]) << OFFSET_BITS;
      d = $random(seed);
      r = $random(seed);
      m = r[`AXI_STRB_BITS-1:0];
      if (do_write)
        write_word(a, d, m);
      else
        read_and_check(a);
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    errors++;
    $display("Run timed out after %0d ns before all tests finished", TIMEOUT_NS);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    errors  = 0;
    checks  = 0;
    seed    = 83;
    rstn    = 1'b0;
    read    = 1'b0;
    write   = 1'b0;
    addr    = '0;
    data_in = '0;
    w_type  = '0;
    for (int i = 0; i < `AXI_MEM_WORDS; i++)
      ref_mem[i] = '0;
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);

    reset_state_check();
    write_read_basic();
    strobe_merge();
    out_of_range_write();
    data_out_hold();
    random_mix();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+src
src/axi_pkg.sv
src/axi_master.sv
src/axi_sram_slave.sv
src/axi_mem_subsys.sv
tests/tb_axi_mem_subsys.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module tb_axi_mem_subsys \
  --Mdir obj_dir \
  -o sim

./obj_dir/sim > sim.log 2>&1
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
